/* Bender.yml */
package:
  name: fetch_frontend

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_isa_pkg.sv
      - rtl/fetch_pkg.sv
      - rtl/fetch_if.sv
      - rtl/early_decode.sv
      - rtl/fetch_unit.sv
      - rtl/scratch_mem.sv
      - rtl/ext_fetch_port.sv
      - rtl/instruction_buffer.sv
      - rtl/fetch_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/ext_mem_model.sv
      - bench/fetch_tb.sv

/* bench/ext_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module ext_mem_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ext_req,
    input  logic [31:0] ext_addr,
    output logic        ext_rvalid,
    output logic [31:0] ext_rdata,
    output logic [31:0] req_addr,
    input  logic [31:0] word_in
);

    integer      seed;
    int unsigned wait_left;
    logic        fire;
    logic [31:0] latched;

    initial begin
        seed       = SEED;
        wait_left  = 0;
        fire       = 1'b0;
        latched    = '0;
        req_addr   = '0;
        ext_rvalid = 1'b0;
    end

    // Memory contents come from the bench, keyed by the held address
    assign ext_rdata = word_in;

    // Response 1 to 6 cycles after each request
    always @(posedge clk) begin
        fire = 1'b0;
        if (rst) begin
            wait_left = 0;
        end else if (ext_req) begin
            latched   = ext_addr;
            wait_left = {$random(seed)} % 6;
            fire      = (wait_left == 0);
        end else if (wait_left != 0) begin
            wait_left = wait_left - 1;
            fire      = (wait_left == 0);
        end
        #1;
        req_addr   = latched;
        ext_rvalid = fire;
    end

endmodule

`default_nettype wire

/* bench/fetch_tb.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"
`default_nettype none

module fetch_tb;

    localparam logic [31:0] SEED   = 32'he1c04282;
    localparam int          PROG_W = $clog2(`SCRATCH_WORDS);

    logic              clk;
    logic              rst;
    logic              redirect_valid;
    logic [31:0]       redirect_pc;
    logic              prog_we;
    logic [PROG_W-1:0] prog_addr;
    logic [31:0]       prog_data;
    logic              ext_req;
    logic [31:0]       ext_addr;
    logic              ext_rvalid;
    logic [31:0]       ext_rdata;
    logic              instr_pop;
    logic              instr_valid;
    logic [31:0]       instr_pc;
    logic [31:0]       instr_word;
    logic              uses_rs1;
    logic              uses_rs2;
    logic              uses_rd;
    logic              rd_zero;
    logic              is_call;
    logic              is_return;

    integer      seed;
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          timeouts = 0;
    int          pops = 0;
    int          cycles = 0;
    int          unpopped_reqs = 0;
    logic        holding = 1'b0;
    logic [31:0] prog_copy [`SCRATCH_WORDS];
    logic [31:0] model_addr;
    logic [31:0] model_word;
    logic [31:0] exp_pc;
    logic [31:0] exp_ext_addr;
    logic [31:0] exp_word;
    logic [5:0]  exp_flags;
    logic [5:0]  got_flags;

    fetch_top DUT (.*);

    ext_mem_model #(.SEED(SEED)) mem_model (
        .clk        (clk),
        .rst        (rst),
        .ext_req    (ext_req),
        .ext_addr   (ext_addr),
        .ext_rvalid (ext_rvalid),
        .ext_rdata  (ext_rdata),
        .req_addr   (model_addr),
        .word_in    (model_word)
    );

    always #50 clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [31:0] ext_word(input logic [31:0] addr);
        return (addr * 32'h0019_660d) + 32'h3c6e_f35f;
    endfunction

    // Calls, returns, SYSTEM forms and JAL x0
    function automatic logic [31:0] special_word(input int k);
        case (k % 8)
            0:       return 32'h0000_00ef;
            1:       return 32'h0000_8067;
            2:       return 32'h0000_0073;
            3:       return 32'h3400_5073;
            4:       return 32'h0000_006f;
            5:       return 32'h0002_80e7;
            6:       return 32'h0002_82e7;
            default: return 32'h3000_22f3;
        endcase
    endfunction

    function automatic logic [5:0] flags_for(input logic [31:0] w);
        logic [4:0] opc;
        logic [2:0] f3;
        logic       jump;
        logic       sys;
        logic       link_rd;
        logic       link_rs1;
        logic [5:0] f;
        opc      = w[6:2];
        f3       = w[14:12];
        jump     = (opc == 5'b11011) || (opc == 5'b11001);
        sys      = (opc == 5'b11100);
        link_rd  = (w[11:7] == 5'd1) || (w[11:7] == 5'd5);
        link_rs1 = (w[19:15] == 5'd1) || (w[19:15] == 5'd5);
        // LUI, AUIPC, JAL, FENCE
        f[5] = !(opc inside {5'b01101, 5'b00101, 5'b11011, 5'b00011})
               && !(sys && ((f3 == 3'b000) || f3[2]));
        // BRANCH, STORE, OP, AMO
        f[4] = opc inside {5'b11000, 5'b01000, 5'b01100, 5'b01011};
        f[3] = !(opc inside {5'b11000, 5'b01000, 5'b00011})
               && !(sys && (f3 == 3'b000)) && !(jump && (w[11:7] == 5'd0));
        f[2] = (w[11:7] == 5'd0);
        f[1] = jump && link_rd;
        f[0] = (opc == 5'b11001) && link_rs1 && (!link_rd || (w[19:15] != w[11:7]));
        return f;
    endfunction

    assign model_word = ext_word(model_addr);
    assign exp_flags  = flags_for(instr_word);
    assign got_flags  = {uses_rs1, uses_rs2, uses_rd, rd_zero, is_call, is_return};

    always_comb begin
        if (instr_pc[31:28] == `SCRATCH_REGION) begin
            exp_word = prog_copy[instr_pc[PROG_W+1:2]];
        end else begin
            exp_word = ext_word(instr_pc);
        end
    end

    // Next PC to pop and next external bus address
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst) begin
            exp_pc <= `FETCH_RESET_VEC;
        end else if (redirect_valid) begin
            exp_pc <= redirect_pc;
        end else if (instr_valid && instr_pop) begin
            exp_pc <= exp_pc + 32'd4;
        end
        if (redirect_valid) begin
            exp_ext_addr <= redirect_pc;
        end else if (ext_req) begin
            exp_ext_addr <= exp_ext_addr + 32'd4;
        end
    end

    // External requests not yet matched by a pop since the last flush
    always @(posedge clk) begin
        if (rst || redirect_valid) begin
            unpopped_reqs <= 0;
        end else begin
            unpopped_reqs <= unpopped_reqs + int'(ext_req) - int'(instr_valid && instr_pop);
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        value_errors++;
        $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
    endtask

    task automatic protocol_error(input string what);
        protocol_errors++;
        $display("Protocol error at %0t: %s", $time, what);
    endtask

    a_pc_order: assert property (@(posedge clk) disable iff (rst)
        instr_valid && instr_pop |-> instr_pc == exp_pc)
        else report_mismatch("instr_pc", $sampled(instr_pc), $sampled(exp_pc));

    a_word: assert property (@(posedge clk) disable iff (rst)
        instr_valid && instr_pop |-> instr_word == exp_word)
        else report_mismatch("instr_word", $sampled(instr_word), $sampled(exp_word));

    a_flags: assert property (@(posedge clk) disable iff (rst)
        instr_valid && instr_pop |-> got_flags == exp_flags)
        else report_mismatch("decode flags", 32'($sampled(got_flags)),
                             32'($sampled(exp_flags)));

    a_ext_addr: assert property (@(posedge clk) disable iff (rst)
        ext_req |-> ext_addr == exp_ext_addr)
        else report_mismatch("ext_addr", $sampled(ext_addr), $sampled(exp_ext_addr));

    a_credit_limit: assert property (@(posedge clk) disable iff (rst)
        ext_req |-> unpopped_reqs < `FETCH_BUF_DEPTH)
        else protocol_error("external request issued beyond the buffer credits");

    a_hold_valid: assert property (@(posedge clk) disable iff (rst)
        holding && instr_valid |=> instr_valid)
        else protocol_error("instr_valid dropped while pops were held off");

    a_reset_quiet: assert property (@(posedge clk)
        (cycles > 0) && (rst || $past(rst)) |-> !instr_valid && !ext_req)
        else protocol_error("instr_valid or ext_req high in or right after reset");

    ////////////////////
    // Stimulus
    ////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic redirect_to(input logic [31:0] target);
        instr_pop      = 1'b0;
        redirect_valid = 1'b1;
        redirect_pc    = target;
        next_cycle();
        redirect_valid = 1'b0;
    endtask

    // Pops at a random rate until n entries have left the buffer
    task automatic pop_entries(input int n);
        int popped;
        int waited;
        popped = 0;
        waited = 0;
        while (popped < n && waited < 20 * n + 50) begin
            instr_pop = instr_valid && (({$random(seed)} % 4) != 0);
            next_cycle();
            if (instr_pop) begin
                popped++;
            end
            waited++;
        end
        instr_pop = 1'b0;
        pops += popped;
        if (popped < n) begin
            timeouts++;
            $display("Timeout: only %0d of %0d entries arrived", popped, n);
        end
    endtask

    task automatic hold_pops(input int n);
        instr_pop = 1'b0;
        holding   = 1'b1;
        repeat (n) next_cycle();
        holding   = 1'b0;
    endtask

    // Redirect while an external fetch is still outstanding
    task automatic redirect_on_ext_req(input logic [31:0] target);
        int waited;
        waited = 0;
        while (!ext_req && waited < 200) begin
            instr_pop = instr_valid;
            next_cycle();
            if (instr_pop) begin
                pops++;
            end
            waited++;
        end
        if (!ext_req) begin
            timeouts++;
            $display("Timeout: no external request came before the redirect");
        end
        redirect_to(target);
    endtask

    initial begin
        seed           = SEED;
        clk            = 1'b0;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        prog_we        = 1'b0;
        prog_addr      = '0;
        prog_data      = '0;
        instr_pop      = 1'b0;

        repeat (5) next_cycle();
        rst = 1'b0;

        // Fetch runs ahead on unloaded words
        // The redirect below drops them
        for (int i = 0; i < `SCRATCH_WORDS; i++) begin
            prog_copy[i] = (i % 4 == 3) ? special_word(i / 4) : $random(seed);
            prog_we      = 1'b1;
            prog_addr    = PROG_W'(i);
            prog_data    = prog_copy[i];
            next_cycle();
        end
        prog_we = 1'b0;

        redirect_to(`FETCH_RESET_VEC);
        pop_entries(40);
        hold_pops(20);
        pop_entries(12);
        redirect_to(`FETCH_RESET_VEC + 32'h100);
        pop_entries(16);
        redirect_to(32'h2000_0000);
        pop_entries(12);
        hold_pops(40);
        pop_entries(8);
        redirect_on_ext_req(32'h2000_1000);
        pop_entries(8);
        redirect_to(`FETCH_RESET_VEC + 32'h200);
        pop_entries(8);
        repeat (3) next_cycle();

        $display("Checks done: %0d value errors, %0d protocol errors, %0d timeouts, %0d pops",
                 value_errors, protocol_errors, timeouts, pops);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/early_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module early_decode
    import rv_isa_pkg::*, fetch_pkg::*;
(
    input  logic [31:0]   instruction,
    output decode_flags_t flags
);

    opcode_class_t opc;
    logic [2:0]    funct3;
    logic [4:0]    rs1;
    logic [4:0]    rd;
    logic          sys_priv;
    logic          sys_csr_imm;
    logic          is_jump;
    logic          rd_link;
    logic          rs1_link;

    assign opc    = opcode_class_t'(instruction[OPC_MSB:OPC_LSB]);
    assign funct3 = instruction[FUNCT3_MSB:FUNCT3_LSB];
    assign rs1    = instruction[RS1_MSB:RS1_LSB];
    assign rd     = instruction[RD_MSB:RD_LSB];

    // ECALL/EBREAK/xRET and the CSR immediate forms
    assign sys_priv    = (opc == OPC_SYSTEM) && (funct3 == 3'b000);
    assign sys_csr_imm = (opc == OPC_SYSTEM) && funct3[2];

    assign is_jump  = (opc == OPC_JAL) || (opc == OPC_JALR);

    // x1 and x5 are the link registers
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    assign flags.uses_rs1 = !((opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_FENCE})
                              || sys_priv || sys_csr_imm);
    assign flags.uses_rs2 = opc inside {OPC_BRANCH, OPC_STORE, OPC_ARITH, OPC_AMO};
    assign flags.uses_rd  = !((opc inside {OPC_BRANCH, OPC_STORE, OPC_FENCE})
                              || sys_priv || (is_jump && (rd == 5'd0)));
    assign flags.rd_zero  = (rd == 5'd0);

    ////////////////////
    // Call and return hints
    ////////////////////
    assign flags.is_call   = is_jump && rd_link;
    assign flags.is_return = (opc == OPC_JALR) && rs1_link
                             && (!rd_link || (rs1 != rd));

endmodule

`default_nettype wire

/* rtl/ext_fetch_port.sv */
`timescale 1ns/1ns
`default_nettype none

module ext_fetch_port (
    input  logic        clk,
    input  logic        rst,
    output logic        ext_req,
    output logic [31:0] ext_addr,
    input  logic        ext_rvalid,
    input  logic [31:0] ext_rdata,
    fetch_sub_if.sub    fetch_sub
);

    logic busy;

    // One request in flight, no storage
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (fetch_sub.new_request) begin
            busy <= 1'b1;
        end else if (ext_rvalid) begin
            busy <= 1'b0;
        end
    end

    // Bus request goes out the cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            ext_req <= 1'b0;
        end else begin
            ext_req <= fetch_sub.new_request;
        end
    end

    // Stage-2 address holds while busy
    assign ext_addr = fetch_sub.stage2_addr;

    assign fetch_sub.ready      = !busy;
    assign fetch_sub.data_valid = ext_rvalid && busy;
    assign fetch_sub.data_out   = ext_rdata;

    ////////////////////
    // Protocol checks
    ////////////////////
    a_no_orphan_rvalid: assert property (@(posedge clk) disable iff (rst)
        ext_rvalid |-> busy);

    // Fetch unit must honor ready across the whole bus latency
    a_single_outstanding: assert property (@(posedge clk) disable iff (rst)
        fetch_sub.new_request |-> !busy);

endmodule

`default_nettype wire

/* rtl/fetch_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Fetch unit to one fetch sub-unit
interface fetch_sub_if;
    logic        new_request;
    logic [31:0] stage1_addr;
    logic [31:0] stage2_addr;
    logic        ready;
    logic        data_valid;
    logic [31:0] data_out;

    modport unit (output new_request, stage1_addr, stage2_addr,
                  input  ready, data_valid, data_out);
    modport sub  (input  new_request, stage1_addr, stage2_addr,
                  output ready, data_valid, data_out);
endinterface

// Fetch unit to instruction buffer, pop doubles as credit return
interface fetch_buffer_if
    import fetch_pkg::*;
();
    logic         push;
    fetch_entry_t entry;
    logic         flush;
    logic         pop;

    modport producer (output push, entry, flush, input pop);
    modport buffer   (input push, entry, flush, output pop);
endinterface

`default_nettype wire

/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // Register usage and call/return hints from early decode
    typedef struct packed {
        logic uses_rs1;
        logic uses_rs2;
        logic uses_rd;
        logic rd_zero;
        logic is_call;
        logic is_return;
    } decode_flags_t;

    // One instruction buffer slot, 70 bits
    typedef struct packed {
        logic [31:0]   pc;
        logic [31:0]   instruction;
        decode_flags_t flags;
    } fetch_entry_t;

endpackage

`default_nettype wire

/* rtl/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

`default_nettype none

// First fetch address after reset, inside the scratch region
`define FETCH_RESET_VEC 32'h8000_0000

// Instruction buffer slots, also the initial credit count
`define FETCH_BUF_DEPTH 4

// Scratch instruction memory size in 32-bit words
`define SCRATCH_WORDS 256

// Address bits 31..28 that select scratch
// Any other value goes to the external port
`define SCRATCH_REGION 4'h8

`default_nettype wire

`endif

/* rtl/fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              redirect_valid,
    input  logic [31:0]                       redirect_pc,
    input  logic                              prog_we,
    input  logic [$clog2(`SCRATCH_WORDS)-1:0] prog_addr,
    input  logic [31:0]                       prog_data,
    output logic                              ext_req,
    output logic [31:0]                       ext_addr,
    input  logic                              ext_rvalid,
    input  logic [31:0]                       ext_rdata,
    input  logic                              instr_pop,
    output logic                              instr_valid,
    output logic [31:0]                       instr_pc,
    output logic [31:0]                       instr_word,
    output logic                              uses_rs1,
    output logic                              uses_rs2,
    output logic                              uses_rd,
    output logic                              rd_zero,
    output logic                              is_call,
    output logic                              is_return
);

    fetch_sub_if    scratch_sub ();
    fetch_sub_if    ext_sub ();
    fetch_buffer_if ib ();

    fetch_entry_t instr_entry;

    fetch_unit fetch_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .scratch_sub    (scratch_sub.unit),
        .ext_sub        (ext_sub.unit),
        .ib             (ib.producer)
    );

    scratch_mem scratch_i (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .fetch_sub (scratch_sub.sub)
    );

    ext_fetch_port ext_i (
        .clk        (clk),
        .rst        (rst),
        .ext_req    (ext_req),
        .ext_addr   (ext_addr),
        .ext_rvalid (ext_rvalid),
        .ext_rdata  (ext_rdata),
        .fetch_sub  (ext_sub.sub)
    );

    instruction_buffer buffer_i (
        .clk         (clk),
        .rst         (rst),
        .instr_pop   (instr_pop),
        .ib          (ib.buffer),
        .instr_valid (instr_valid),
        .instr_entry (instr_entry)
    );

    // Buffer head out to the issue stage
    assign instr_pc   = instr_entry.pc;
    assign instr_word = instr_entry.instruction;
    assign uses_rs1   = instr_entry.flags.uses_rs1;
    assign uses_rs2   = instr_entry.flags.uses_rs2;
    assign uses_rd    = instr_entry.flags.uses_rd;
    assign rd_zero    = instr_entry.flags.rd_zero;
    assign is_call    = instr_entry.flags.is_call;
    assign is_return  = instr_entry.flags.is_return;

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          redirect_valid,
    input  logic [31:0]   redirect_pc,
    fetch_sub_if.unit     scratch_sub,
    fetch_sub_if.unit     ext_sub,
    fetch_buffer_if.producer ib
);

    localparam int CREDIT_W = $clog2(`FETCH_BUF_DEPTH + 1);

    logic [31:0]         pc;
    logic [31:0]         stage2_addr;
    logic                stage2_is_ext;
    logic [CREDIT_W-1:0] credits;
    logic                discard;
    logic                in_scratch;
    logic                issue;
    logic                any_valid;
    logic [31:0]         fetched_word;
    decode_flags_t       fetched_flags;

    ////////////////////
    // Request issue
    ////////////////////

    // No issue in a redirect cycle
    // The target goes out one cycle later
    assign issue = (credits != '0) && scratch_sub.ready && ext_sub.ready
                   && !redirect_valid;

    assign in_scratch = (pc[31:28] == `SCRATCH_REGION);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FETCH_RESET_VEC;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
    end

    assign scratch_sub.new_request = issue && in_scratch;
    assign ext_sub.new_request     = issue && !in_scratch;
    assign scratch_sub.stage1_addr = pc;
    assign ext_sub.stage1_addr     = pc;
    assign scratch_sub.stage2_addr = stage2_addr;
    assign ext_sub.stage2_addr     = stage2_addr;

    // Address and target of the request now in flight
    always_ff @(posedge clk) begin
        if (issue) begin
            stage2_addr <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage2_is_ext <= 1'b0;
        end else if (issue) begin
            stage2_is_ext <= !in_scratch;
        end
    end

    ////////////////////
    // Credits
    ////////////////////

    // Spend one per issue and get one back per pop
    // Flush refills the count
    always_ff @(posedge clk) begin
        if (rst || redirect_valid) begin
            credits <= CREDIT_W'(`FETCH_BUF_DEPTH);
        end else begin
            credits <= credits + CREDIT_W'(ib.pop) - CREDIT_W'(issue);
        end
    end

    // Stale external response still on its way after a redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            discard <= 1'b0;
        end else if (redirect_valid && stage2_is_ext && !ext_sub.ready
                     && !ext_sub.data_valid) begin
            discard <= 1'b1;
        end else if (ext_sub.data_valid) begin
            discard <= 1'b0;
        end
    end

    ////////////////////
    // Merge and push
    ////////////////////
    assign fetched_word = (scratch_sub.data_out & {32{scratch_sub.data_valid}})
                        | (ext_sub.data_out & {32{ext_sub.data_valid}});

    assign any_valid = scratch_sub.data_valid || ext_sub.data_valid;

    early_decode decode_i (
        .instruction (fetched_word),
        .flags       (fetched_flags)
    );

    assign ib.push              = any_valid && !redirect_valid && !discard;
    assign ib.flush             = redirect_valid;
    assign ib.entry.pc          = stage2_addr;
    assign ib.entry.instruction = fetched_word;
    assign ib.entry.flags       = fetched_flags;

    // While a stale response is pending only that external response can arrive
    a_discard_pending: assert property (@(posedge clk) disable iff (rst)
        discard |-> !ext_sub.ready && !scratch_sub.data_valid);

endmodule

`default_nettype wire

/* rtl/instruction_buffer.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"
`default_nettype none

module instruction_buffer
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          instr_pop,
    fetch_buffer_if.buffer ib,
    output logic          instr_valid,
    output fetch_entry_t  instr_entry
);

    localparam int PTR_W   = $clog2(`FETCH_BUF_DEPTH);
    localparam int COUNT_W = $clog2(`FETCH_BUF_DEPTH + 1);

    fetch_entry_t       entries [`FETCH_BUF_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_pop;

    assign do_pop = instr_pop && instr_valid;

    always_ff @(posedge clk) begin
        if (ib.push) begin
            entries[wr_ptr] <= ib.entry;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || ib.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (ib.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (ib.push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !ib.push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head shows without a read cycle
    assign instr_valid = (count != '0);
    assign instr_entry = entries[rd_ptr];

    // Credit return
    assign ib.pop = instr_pop;

    ////////////////////
    // Credit and handshake checks
    ////////////////////
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        ib.push |-> (count < COUNT_W'(`FETCH_BUF_DEPTH)));

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        instr_pop |-> instr_valid);

endmodule

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    ////////////////////
    // Major opcode classes, bits 6..2 of the opcode
    ////////////////////
    typedef enum logic [4:0] {
        OPC_LOAD      = 5'b00000,
        OPC_FENCE     = 5'b00011,
        OPC_ARITH_IMM = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_STORE     = 5'b01000,
        OPC_AMO       = 5'b01011,
        OPC_ARITH     = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_BRANCH    = 5'b11000,
        OPC_JALR      = 5'b11001,
        OPC_JAL       = 5'b11011,
        OPC_SYSTEM    = 5'b11100
    } opcode_class_t;

    ////////////////////
    // Field positions in a 32-bit instruction
    ////////////////////
    localparam int OPC_LSB    = 2;
    localparam int OPC_MSB    = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int RS1_LSB    = 15;
    localparam int RS1_MSB    = 19;

endpackage

`default_nettype wire

/* rtl/scratch_mem.sv */
`timescale 1ns/1ns
`include "fetch_settings.svh"
`default_nettype none

module scratch_mem #(
    parameter int ADDR_W = $clog2(`SCRATCH_WORDS)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              prog_we,
    input  logic [ADDR_W-1:0] prog_addr,
    input  logic [31:0]       prog_data,
    fetch_sub_if.sub          fetch_sub
);

    logic [31:0]       mem [`SCRATCH_WORDS];
    logic [ADDR_W-1:0] rd_index;

    // Word index from the byte address
    assign rd_index = fetch_sub.stage1_addr[ADDR_W+1:2];

    // Program load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_sub.new_request) begin
            fetch_sub.data_out <= mem[rd_index];
        end
    end

    // Data one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_sub.data_valid <= 1'b0;
        end else begin
            fetch_sub.data_valid <= fetch_sub.new_request;
        end
    end

    // Single-cycle, never stalls
    assign fetch_sub.ready = 1'b1;

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_if.sv
rtl/early_decode.sv
rtl/fetch_unit.sv
rtl/scratch_mem.sv
rtl/ext_fetch_port.sv
rtl/instruction_buffer.sv
rtl/fetch_top.sv
bench/ext_mem_model.sv
bench/fetch_tb.sv
